//--- common/rsa_pkg.sv
// shared types and default sizes for the systolic matrix engine

package rsa_pkg;

    // one matrix element
    // products and sums wrap modulo 2^16, so only the low 16 bits are kept
    typedef logic [15:0] data_t;

    // result adder mode, applied per output row
    // R = C, M + C, M - C or C - M
    typedef enum logic [1:0] {
        MODE_C         = 2'b00,
        MODE_M_PLUS_C  = 2'b01,
        MODE_M_MINUS_C = 2'b10,
        MODE_C_MINUS_M = 2'b11
    } mode_t;

    // default array height (rows of A and R)
    localparam int ROWS_DEF = 4;

    // default array width (columns of B and R)
    localparam int COLS_DEF = 4;

endpackage

//--- rtl/rsa_drain.sv
// result drain: chain shift-out, M combine by mode and output stream

`timescale 1ns/1ps

module rsa_drain #(
    parameter int ROWS = rsa_pkg::ROWS_DEF,
    parameter int COLS = rsa_pkg::COLS_DEF
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  rsa_pkg::mode_t            i_mode,
    // corner PE done, every sum is in its chain register
    input  logic                      i_all_done,
    // column 0 chain outputs, one per row
    input  rsa_pkg::data_t [ROWS-1:0] i_chain,
    // M stream
    input  logic                      i_m_val,
    output logic                      o_m_rdy,
    input  rsa_pkg::data_t [ROWS-1:0] i_m,
    // result stream
    output logic                      o_out_val,
    input  logic                      i_out_rdy,
    output rsa_pkg::data_t [ROWS-1:0] o_out_c,
    // grid and feeder control
    output logic                      o_shift,
    output logic                      o_free
);

    localparam int CW = $clog2(COLS);

    logic                      run_q;
    logic [CW-1:0]             cnt_q;
    logic                      last_q;
    logic                      m_fire;
    logic                      cnt_end;
    rsa_pkg::data_t [ROWS-1:0] res;

    // take M only when the output register is free or emptying now
    assign o_m_rdy = run_q && (!o_out_val || i_out_rdy);
    assign m_fire  = o_m_rdy && i_m_val;
    assign cnt_end = (cnt_q == CW'(COLS - 1));

    // each accepted beat moves the next column into column 0
    assign o_shift = m_fire;

    // per-row result adder
    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            case (i_mode)
                rsa_pkg::MODE_M_PLUS_C:  res[r] = i_m[r] + i_chain[r];
                rsa_pkg::MODE_M_MINUS_C: res[r] = i_m[r] - i_chain[r];
                rsa_pkg::MODE_C_MINUS_M: res[r] = i_chain[r] - i_m[r];
                default:                 res[r] = i_chain[r];
            endcase
        end
    end

    // beat counter and output valid
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            run_q     <= 1'b0;
            cnt_q     <= '0;
            last_q    <= 1'b0;
            o_out_val <= 1'b0;
            o_free    <= 1'b0;
        end else begin
            // release once the final column has left
            o_free <= o_out_val && i_out_rdy && last_q;
            if (i_all_done) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (m_fire) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_end) begin
                    run_q <= 1'b0;
                end
            end
            if (m_fire) begin
                o_out_val <= 1'b1;
                last_q    <= cnt_end;
            end else if (i_out_rdy) begin
                o_out_val <= 1'b0;
                last_q    <= 1'b0;
            end
        end
    end

    // result register, loaded only on an accepted M column
    always_ff @(posedge clk) begin
        if (m_fire) begin
            o_out_c <= res;
        end
    end

    // a stalled result holds its value and stays offered
    a_out_hold : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        o_out_val && !i_out_rdy |=> o_out_val && $stable(o_out_c)
    ) else $error("rsa_drain: result changed while stalled");

endmodule

//--- rtl/rsa_feeder.sv
// operand feeder: input handshake, job tracking, mode hold and row/column skew

`timescale 1ns/1ps

module rsa_feeder #(
    parameter int ROWS = rsa_pkg::ROWS_DEF,
    parameter int COLS = rsa_pkg::COLS_DEF
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    // operand stream, one k per beat
    input  logic                      i_in_val,
    output logic                      o_in_rdy,
    input  rsa_pkg::data_t [ROWS-1:0] i_in_a,
    input  rsa_pkg::data_t [COLS-1:0] i_in_b,
    input  logic                      i_in_last,
    input  rsa_pkg::mode_t            i_in_mode,
    // release from the drain after the last result beat
    input  logic                      i_free,
    // skewed west edge of the grid
    output rsa_pkg::data_t [ROWS-1:0] o_row_a,
    output logic [ROWS-1:0]           o_row_en,
    output logic [ROWS-1:0]           o_row_clear,
    output logic [ROWS-1:0]           o_row_done,
    // skewed south edge of the grid
    output rsa_pkg::data_t [COLS-1:0] o_col_b,
    // mode of the job in flight
    output rsa_pkg::mode_t            o_mode
);

    logic fire;
    logic first_q;
    logic rdy_q;

    assign fire     = i_in_val && rdy_q;
    assign o_in_rdy = rdy_q;

    // first_q marks the next beat as the start of a job
    // input closes after the last beat and reopens on release
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            first_q <= 1'b1;
            rdy_q   <= 1'b1;
            o_mode  <= rsa_pkg::MODE_C;
        end else begin
            if (fire) begin
                first_q <= i_in_last;
            end
            if (fire && first_q) begin
                o_mode <= i_in_mode;
            end
            if (fire && i_in_last) begin
                rdy_q <= 1'b0;
            end else if (i_free) begin
                rdy_q <= 1'b1;
            end
        end
    end

    // row r: r+1 stages, A word plus enable/clear/done travel together
    for (genvar r = 0; r < ROWS; r++) begin : g_row
        rsa_pkg::data_t a_sr [0:r];
        logic [r:0]     en_sr;
        logic [r:0]     clear_sr;
        logic [r:0]     done_sr;

        always_ff @(posedge clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                en_sr    <= '0;
                clear_sr <= '0;
                done_sr  <= '0;
            end else begin
                en_sr[0]    <= fire;
                clear_sr[0] <= fire && first_q;
                done_sr[0]  <= fire && i_in_last;
                for (int i = 1; i <= r; i++) begin
                    en_sr[i]    <= en_sr[i-1];
                    clear_sr[i] <= clear_sr[i-1];
                    done_sr[i]  <= done_sr[i-1];
                end
            end
        end

        // payload shifts every cycle, the enable qualifies it
        always_ff @(posedge clk) begin
            a_sr[0] <= i_in_a[r];
            for (int i = 1; i <= r; i++) begin
                a_sr[i] <= a_sr[i-1];
            end
        end

        assign o_row_a[r]     = a_sr[r];
        assign o_row_en[r]    = en_sr[r];
        assign o_row_clear[r] = clear_sr[r];
        assign o_row_done[r]  = done_sr[r];
    end

    // column c: c+1 stages of B
    for (genvar c = 0; c < COLS; c++) begin : g_col
        rsa_pkg::data_t b_sr [0:c];

        always_ff @(posedge clk) begin
            b_sr[0] <= i_in_b[c];
            for (int i = 1; i <= c; i++) begin
                b_sr[i] <= b_sr[i-1];
            end
        end

        assign o_col_b[c] = b_sr[c];
    end

    // release only comes for a closed input, so no job's beats can overlap
    a_free_when_closed : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_free |-> !o_in_rdy
    ) else $error("rsa_feeder: release seen while input open");

endmodule

//--- rtl/rsa_pe.sv
// processing element: multiply-accumulate, operand and control forwarding, result chain stage

`timescale 1ns/1ps

module rsa_pe (
    input  logic           clk,
    input  logic           i_rst_n,
    // control arriving from the west with the A operand
    input  logic           i_en,
    input  logic           i_clear,
    input  logic           i_done,
    // operands
    input  rsa_pkg::data_t i_west,
    input  rsa_pkg::data_t i_south,
    // result chain from the east neighbor
    input  rsa_pkg::data_t i_chain,
    input  logic           i_shift,
    // forwarded control and operands
    output logic           o_en,
    output logic           o_clear,
    output logic           o_done,
    output rsa_pkg::data_t o_east,
    output rsa_pkg::data_t o_north,
    // chain register, read by the west neighbor or by the drain
    output rsa_pkg::data_t o_chain
);

    rsa_pkg::data_t prod;
    rsa_pkg::data_t mac_next;
    rsa_pkg::data_t sum_q;

    // low 16 bits of the product only
    assign prod = i_west * i_south;

    // first operand of a job restarts the sum
    assign mac_next = i_clear ? prod : sum_q + prod;

    // control moves east one PE per cycle
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_en    <= 1'b0;
            o_clear <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            o_en    <= i_en;
            o_clear <= i_clear;
            o_done  <= i_done;
        end
    end

    // operand forwarding, A goes east and B goes north
    always_ff @(posedge clk) begin
        o_east  <= i_west;
        o_north <= i_south;
    end

    // accumulator
    always_ff @(posedge clk) begin
        if (i_en) begin
            sum_q <= mac_next;
        end
    end

    // chain stage
    // the last operand is folded in on the same edge it loads the chain,
    // shifting only starts once the whole grid is done
    always_ff @(posedge clk) begin
        if (i_en && i_done) begin
            o_chain <= mac_next;
        end else if (i_shift) begin
            o_chain <= i_chain;
        end
    end

    // the done flag rides on the last enabled beat, so the feeder skew
    // and every PE on the way must keep the two together
    a_done_with_en : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_done |-> i_en
    ) else $error("rsa_pe: done seen without enable");

endmodule

//--- rtl/rsa_top.sv
// top level: feeder, generate grid of PEs and drain

`timescale 1ns/1ps

module rsa_top #(
    parameter int ROWS = rsa_pkg::ROWS_DEF,
    parameter int COLS = rsa_pkg::COLS_DEF
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    // operand stream
    input  logic                      i_in_val,
    output logic                      o_in_rdy,
    input  rsa_pkg::data_t [ROWS-1:0] i_in_a,
    input  rsa_pkg::data_t [COLS-1:0] i_in_b,
    input  logic                      i_in_last,
    input  rsa_pkg::mode_t            i_in_mode,
    // M stream
    input  logic                      i_m_val,
    output logic                      o_m_rdy,
    input  rsa_pkg::data_t [ROWS-1:0] i_m,
    // result stream
    output logic                      o_out_val,
    input  logic                      i_out_rdy,
    output rsa_pkg::data_t [ROWS-1:0] o_out_c
);

    // feeder outputs
    rsa_pkg::data_t [ROWS-1:0] row_a;
    logic [ROWS-1:0]           row_en;
    logic [ROWS-1:0]           row_clear;
    logic [ROWS-1:0]           row_done;
    rsa_pkg::data_t [COLS-1:0] col_b;
    rsa_pkg::mode_t            mode;

    // drain side
    rsa_pkg::data_t [ROWS-1:0] chain_col;
    logic                      shift;
    logic                      free;
    logic                      all_done;

    // grid nets
    // [r][c] is the west input of PE(r,c), [r][c+1] its east output
    wire rsa_pkg::data_t a_w     [ROWS][COLS+1];
    wire                 en_w    [ROWS][COLS+1];
    wire                 clear_w [ROWS][COLS+1];
    wire                 done_w  [ROWS][COLS+1];
    // [r][c] is the south input of PE(r,c), [r+1][c] its north output
    wire rsa_pkg::data_t b_s     [ROWS+1][COLS];
    // [r][c] is the chain output of PE(r,c), read by PE(r,c-1)
    wire rsa_pkg::data_t chain   [ROWS][COLS+1];

    rsa_feeder #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_feeder (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_in_val    (i_in_val),
        .o_in_rdy    (o_in_rdy),
        .i_in_a      (i_in_a),
        .i_in_b      (i_in_b),
        .i_in_last   (i_in_last),
        .i_in_mode   (i_in_mode),
        .i_free      (free),
        .o_row_a     (row_a),
        .o_row_en    (row_en),
        .o_row_clear (row_clear),
        .o_row_done  (row_done),
        .o_col_b     (col_b),
        .o_mode      (mode)
    );

    // west edge from the feeder, east end of the chain tied off,
    // column 0 of the chain to the drain
    for (genvar r = 0; r < ROWS; r++) begin : g_edge_row
        assign a_w[r][0]     = row_a[r];
        assign en_w[r][0]    = row_en[r];
        assign clear_w[r][0] = row_clear[r];
        assign done_w[r][0]  = row_done[r];
        assign chain[r][COLS] = '0;
        assign chain_col[r]  = chain[r][0];
    end

    // south edge from the feeder
    for (genvar c = 0; c < COLS; c++) begin : g_edge_col
        assign b_s[0][c] = col_b[c];
    end

    for (genvar r = 0; r < ROWS; r++) begin : g_pe_row
        for (genvar c = 0; c < COLS; c++) begin : g_pe_col
            rsa_pe u_pe (
                .clk     (clk),
                .i_rst_n (i_rst_n),
                .i_en    (en_w[r][c]),
                .i_clear (clear_w[r][c]),
                .i_done  (done_w[r][c]),
                .i_west  (a_w[r][c]),
                .i_south (b_s[r][c]),
                .i_chain (chain[r][c+1]),
                .i_shift (shift),
                .o_en    (en_w[r][c+1]),
                .o_clear (clear_w[r][c+1]),
                .o_done  (done_w[r][c+1]),
                .o_east  (a_w[r][c+1]),
                .o_north (b_s[r+1][c]),
                .o_chain (chain[r][c])
            );
        end
    end

    // corner PE sees the last k latest
    assign all_done = done_w[ROWS-1][COLS];

    rsa_drain #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) u_drain (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_mode     (mode),
        .i_all_done (all_done),
        .i_chain    (chain_col),
        .i_m_val    (i_m_val),
        .o_m_rdy    (o_m_rdy),
        .i_m        (i_m),
        .o_out_val  (o_out_val),
        .i_out_rdy  (i_out_rdy),
        .o_out_c    (o_out_c),
        .o_shift    (shift),
        .o_free     (free)
    );

endmodule

//--- sim.f
common/rsa_pkg.sv
rtl/rsa_pe.sv
rtl/rsa_feeder.sv
rtl/rsa_drain.sv
rtl/rsa_top.sv
test/rsa_clk_gen.sv
test/rsa_tb.sv

//--- test/rsa_clk_gen.sv
// testbench clock generator, free running with a fixed period

`timescale 1ns/1ps

module rsa_clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic o_clk
);

    // low for the first half period, then toggles every half period
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

endmodule

//--- test/rsa_tb.sv
// testbench for rsa_top: job stimulus, reference model, checking assertions and timeout

`timescale 1ns/1ps

module rsa_tb;

    localparam int ROWS        = rsa_pkg::ROWS_DEF;
    localparam int COLS        = rsa_pkg::COLS_DEF;
    localparam int N_JOBS      = 7;
    localparam int K_MAX       = 15;
    localparam int MAX_BEATS   = N_JOBS * COLS;
    localparam int CYCLE_LIMIT = N_JOBS * (K_MAX + ROWS + 3 * COLS + 40);

    logic                      clk;
    logic                      rst_n;
    logic                      in_val;
    logic                      in_rdy;
    rsa_pkg::data_t [ROWS-1:0] in_a;
    rsa_pkg::data_t [COLS-1:0] in_b;
    logic                      in_last;
    rsa_pkg::mode_t            in_mode;
    logic                      m_val;
    logic                      m_rdy;
    rsa_pkg::data_t [ROWS-1:0] m_col;
    logic                      out_val;
    logic                      out_rdy;
    rsa_pkg::data_t [ROWS-1:0] out_c;

    integer                    seed;
    logic [31:0]               stall_rnd;
    logic                      stall_on;
    int                        val_errs = 0;
    int                        proto_errs = 0;

    // operands of the job in flight, A by column k, B by row k, M by output beat
    rsa_pkg::data_t [ROWS-1:0] a_cols [0:K_MAX-1];
    rsa_pkg::data_t [COLS-1:0] b_rows [0:K_MAX-1];
    rsa_pkg::data_t [ROWS-1:0] m_cols [0:COLS-1];

    // expected result beats of every job, in output order
    rsa_pkg::data_t [ROWS-1:0] exp_mem [0:MAX_BEATS-1];
    rsa_pkg::data_t [ROWS-1:0] exp_head;
    int                        exp_wr;

    // transfer counts, advanced on the rising edge
    int                        in_acc;
    int                        m_acc;
    int                        out_acc;
    // set from the last input beat of a job until its last result beat
    logic                      busy;

    rsa_clk_gen #(
        .PERIOD_NS (100)
    ) u_clk_gen (
        .o_clk (clk)
    );

    rsa_top #(
        .ROWS (ROWS),
        .COLS (COLS)
    ) rsa_top_inst (
        .clk       (clk),
        .i_rst_n   (rst_n),
        .i_in_val  (in_val),
        .o_in_rdy  (in_rdy),
        .i_in_a    (in_a),
        .i_in_b    (in_b),
        .i_in_last (in_last),
        .i_in_mode (in_mode),
        .i_m_val   (m_val),
        .o_m_rdy   (m_rdy),
        .i_m       (m_col),
        .o_out_val (out_val),
        .i_out_rdy (out_rdy),
        .o_out_c   (out_c)
    );

    assign exp_head = exp_mem[out_acc];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_acc  <= 0;
            m_acc   <= 0;
            out_acc <= 0;
            busy    <= 1'b0;
        end else begin
            if (in_val && in_rdy) begin
                in_acc <= in_acc + 1;
            end
            if (m_val && m_rdy) begin
                m_acc <= m_acc + 1;
            end
            if (out_val && out_rdy) begin
                out_acc <= out_acc + 1;
            end
            // every job ends with its COLS-th result beat
            if (in_val && in_rdy && in_last) begin
                busy <= 1'b1;
            end else if (out_val && out_rdy && (out_acc % COLS == COLS - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // one random word per cycle, stall bits are read on the next falling edge
    always @(posedge clk) begin
        stall_rnd <= $random(seed);
    end

    // result back-pressure, bit 0 of the stall word
    initial begin
        out_rdy = 1'b0;
        forever begin
            @(negedge clk);
            out_rdy = !stall_on || stall_rnd[0];
        end
    end

    // R = C, M + C, M - C or C - M, all modulo 2^16
    function automatic rsa_pkg::data_t apply_mode(input rsa_pkg::mode_t mode,
                                                  input rsa_pkg::data_t m,
                                                  input rsa_pkg::data_t c);
        case (mode)
            rsa_pkg::MODE_M_PLUS_C:  return m + c;
            rsa_pkg::MODE_M_MINUS_C: return m - c;
            rsa_pkg::MODE_C_MINUS_M: return c - m;
            default:                 return c;
        endcase
    endfunction

    // one job: draw operands, predict results, stream A/B and M, wait for all beats
    task automatic run_job(input int k_len, input rsa_pkg::mode_t mode, input bit stall);
        logic [31:0]    rnd;
        logic [31:0]    prod;
        rsa_pkg::data_t acc;
        int             in_base;
        int             m_base;
        for (int k = 0; k < k_len; k++) begin
            for (int r = 0; r < ROWS; r++) begin
                rnd = $random(seed);
                a_cols[k][r] = rnd[15:0];
            end
            for (int c = 0; c < COLS; c++) begin
                rnd = $random(seed);
                b_rows[k][c] = rnd[15:0];
            end
        end
        for (int j = 0; j < COLS; j++) begin
            for (int r = 0; r < ROWS; r++) begin
                rnd = $random(seed);
                m_cols[j][r] = rnd[15:0];
            end
        end
        // beat j is column j of A x B, sums keep their low 16 bits
        for (int j = 0; j < COLS; j++) begin
            for (int r = 0; r < ROWS; r++) begin
                acc = '0;
                for (int k = 0; k < k_len; k++) begin
                    prod = a_cols[k][r] * b_rows[k][j];
                    acc  = acc + prod[15:0];
                end
                exp_mem[exp_wr + j][r] = apply_mode(mode, m_cols[j][r], acc);
            end
        end
        exp_wr   = exp_wr + COLS;
        stall_on = stall;
        in_base  = in_acc;
        m_base   = m_acc;
        fork
            begin : feed_operands
                int idx;
                while (in_acc - in_base < k_len) begin
                    idx     = in_acc - in_base;
                    in_val  = !stall_on || stall_rnd[2];
                    in_a    = a_cols[idx];
                    in_b    = b_rows[idx];
                    in_last = (idx == k_len - 1);
                    in_mode = mode;
                    @(negedge clk);
                end
                in_val  = 1'b0;
                in_last = 1'b0;
            end
            begin : feed_m
                int idx;
                while (m_acc - m_base < COLS) begin
                    idx   = m_acc - m_base;
                    m_val = !stall_on || stall_rnd[1];
                    m_col = m_cols[idx];
                    @(negedge clk);
                end
                m_val = 1'b0;
            end
        join
        while (out_acc < exp_wr) begin
            @(negedge clk);
        end
        stall_on = 1'b0;
    endtask

    task automatic finish_run(input bit timed_out);
        $display("summary: %0d result beats, %0d value errors, %0d protocol errors",
                 out_acc, val_errs, proto_errs);
        if (timed_out || (val_errs + proto_errs) != 0) begin
            $display("CHECKS FAILED");
        end else begin
            $display("ALL CHECKS PASSED");
        end
        $finish;
    endtask

    // streams idle right after reset
    a_reset_state : assert property (
        @(posedge clk) $rose(rst_n) |-> in_rdy && !out_val && !m_rdy
    ) else begin
        proto_errs = proto_errs + 1;
        $display("FAILED at %0t: stream flags wrong after reset", $time);
    end

    // every transferred beat matches the reference, in order
    a_beat_value : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_val && out_rdy |-> out_c == exp_head
    ) else begin
        val_errs = val_errs + 1;
        $display("FAILED at %0t: result beat %0d is %h, expected %h", $time,
                 $sampled(out_acc), $sampled(out_c), $sampled(exp_head));
    end

    // no result beat beyond what the jobs produce
    a_beat_expected : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_val |-> out_acc < exp_wr
    ) else begin
        proto_errs = proto_errs + 1;
        $display("FAILED at %0t: result offered with no job pending", $time);
    end

    // stalled result keeps its value
    a_stall_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        out_val && !out_rdy |=> out_val && $stable(out_c)
    ) else begin
        val_errs = val_errs + 1;
        $display("FAILED at %0t: result changed or dropped while stalled", $time);
    end

    // input stays closed until the job's last result beat has left
    a_input_closed : assert property (
        @(posedge clk) disable iff (!rst_n)
        busy |-> !in_rdy
    ) else begin
        proto_errs = proto_errs + 1;
        $display("FAILED at %0t: input open while a job is in flight", $time);
    end

    initial begin : watchdog
        int cycle_cnt;
        cycle_cnt = 0;
        while (cycle_cnt < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_cnt = cycle_cnt + 1;
        end
        $display("timeout: run stopped after %0d cycles with %0d of %0d result beats seen",
                 cycle_cnt, out_acc, exp_wr);
        finish_run(1'b1);
    end

    initial begin
        seed     = 32'ha667_3316;
        rst_n    = 1'b0;
        in_val   = 1'b0;
        in_a     = '0;
        in_b     = '0;
        in_last  = 1'b0;
        in_mode  = rsa_pkg::MODE_C;
        m_val    = 1'b0;
        m_col    = '0;
        stall_on = 1'b0;
        exp_wr   = 0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        // plain product, then each adder mode
        run_job(4, rsa_pkg::MODE_C, 1'b0);
        run_job(4, rsa_pkg::MODE_M_PLUS_C, 1'b0);
        run_job(4, rsa_pkg::MODE_M_MINUS_C, 1'b0);
        run_job(4, rsa_pkg::MODE_C_MINUS_M, 1'b0);
        // random stalls on every stream
        run_job(4, rsa_pkg::MODE_C, 1'b1);
        // shortest and longest jobs back to back
        run_job(1, rsa_pkg::MODE_M_PLUS_C, 1'b0);
        run_job(K_MAX, rsa_pkg::MODE_C_MINUS_M, 1'b0);
        finish_run(1'b0);
    end

endmodule
